/* rtl/wr_in_pkg.sv */
// --------------------------------------------------------------------------
// Shared constants for the write-side front end.
// Fixed 64-bit data bus, packed eight beats to one 512-bit word.
// ID_DEPTH must stay a power of two because the ID FIFO pointers wrap freely.
// --------------------------------------------------------------------------
`default_nettype none

package wr_in_pkg;

	// Address channel widths
	localparam int ID_BITS  = 8;
	localparam int ADR_BITS = 64;
	localparam int LEN_BITS = 8;

	// Beat and packed word widths
	localparam int DATA_BITS      = 64;
	localparam int STRB_BITS      = DATA_BITS / 8;
	localparam int WORD_BITS      = 512;
	localparam int WORD_STRB_BITS = WORD_BITS / 8;
	localparam int BEATS_PER_WORD = WORD_BITS / DATA_BITS;
	localparam int CNT_BITS       = 3;

	// Address alignment and size code for the 64-bit bus
	localparam int              ADDR_MASK_BITS = 3;
	localparam logic [2:0]      SIZE_CODE      = 3'd3;

	// ----------------------------------------------------------------------
	// Address record, 128 bits
	// ----------------------------------------------------------------------
	localparam int ADR_REC_BITS   = 128;
	localparam int REC_FIELD_BITS = 16;
	localparam int REC_SIZE_LSB   = 112;
	localparam int REC_ID_LSB     = 96;
	localparam int REC_LEN_LSB    = 80;
	// Two sideband bytes, always zero here
	localparam int REC_SB_LSB     = 64;
	localparam int REC_ADR_LSB    = 0;

	// Data record: zero bit, last, 64 strobes, 512 data bits
	localparam int DAT_REC_BITS = 2 + WORD_STRB_BITS + WORD_BITS;

	// ID queue
	localparam int ID_DEPTH     = 8;
	localparam int ID_PTR_BITS  = $clog2(ID_DEPTH);

	// Write response code
	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* rtl/wr_id_if.sv */
// --------------------------------------------------------------------------
// Burst ID queue connection.
// Push only while full is low, pop only while empty is low.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface wr_id_if;
	import wr_in_pkg::*;

	logic               push;
	logic [ID_BITS-1:0] push_id;
	logic               full;
	logic               pop;
	logic [ID_BITS-1:0] pop_id;
	logic               empty;

	// Address stage side
	modport push_side (output push, output push_id, input full);

	// Response stage side
	modport pop_side (output pop, input pop_id, input empty);

	// The queue itself
	modport fifo_side (
		input  push,
		input  push_id,
		input  pop,
		output full,
		output pop_id,
		output empty
	);

endinterface

`default_nettype wire

/* rtl/wr_id_fifo.sv */
// --------------------------------------------------------------------------
// In-order queue of accepted burst IDs.
// Push and pop may share a cycle. pop_id shows the oldest entry and is
// undefined while empty is high.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_id_fifo (
	input  logic S_CLK,
	input  logic S_RESET_N,
	wr_id_if.fifo_side q
);
	import wr_in_pkg::*;

	logic [ID_BITS-1:0]     mem [ID_DEPTH];
	logic [ID_PTR_BITS-1:0] wr_ptr;
	logic [ID_PTR_BITS-1:0] rd_ptr;
	logic [ID_PTR_BITS:0]   count;
	logic                   do_push;
	logic                   do_pop;

	assign q.full  = (count == (ID_PTR_BITS + 1)'(ID_DEPTH));
	assign q.empty = (count == '0);

	// Guard against a misbehaving producer or consumer
	assign do_push = q.push & ~q.full;
	assign do_pop  = q.pop & ~q.empty;

	assign q.pop_id = mem[rd_ptr];

	always_ff @(posedge S_CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= q.push_id;
		end
	end

	// Pointers wrap at the power-of-two depth
	always_ff @(posedge S_CLK or negedge S_RESET_N) begin
		if (!S_RESET_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/wr_addr_stage.sv */
// --------------------------------------------------------------------------
// Write address acceptance.
// awready is a one-cycle pulse raised only with room in both the address
// FIFO and the ID FIFO, so back-to-back accepts are two cycles apart.
// Lock, cache, protection, QoS and user sideband are not carried.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_addr_stage (
	input  logic                          S_CLK,
	input  logic                          S_RESET_N,
	input  logic [wr_in_pkg::ID_BITS-1:0]  awid,
	input  logic [wr_in_pkg::ADR_BITS-1:0] awaddr,
	input  logic [wr_in_pkg::LEN_BITS-1:0] awlen,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic                          adr_fifo_full,
	output logic                          adr_fifo_wren,
	output logic [wr_in_pkg::ADR_REC_BITS-1:0] adr_fifo_wdata,
	wr_id_if.push_side                    q
);
	import wr_in_pkg::*;

	logic                accept;
	logic [ADR_BITS-1:0] addr_aligned;

	// ----------------------------------------------------------------------
	// Ready pulse
	// ----------------------------------------------------------------------
	always_ff @(posedge S_CLK or negedge S_RESET_N) begin
		if (!S_RESET_N) begin
			awready <= 1'b0;
		end else if (awvalid && !awready && !adr_fifo_full && !q.full) begin
			awready <= 1'b1;
		end else begin
			awready <= 1'b0;
		end
	end

	assign accept = awvalid & awready;

	// Record write and ID push on the same handshake
	assign adr_fifo_wren = accept;
	assign q.push        = accept;
	assign q.push_id     = awid;

	// ----------------------------------------------------------------------
	// Address record
	// ----------------------------------------------------------------------
	// Clear the byte offset within one bus beat
	assign addr_aligned = {awaddr[ADR_BITS-1:ADDR_MASK_BITS], {ADDR_MASK_BITS{1'b0}}};

	assign adr_fifo_wdata[REC_SIZE_LSB +: REC_FIELD_BITS] = REC_FIELD_BITS'(SIZE_CODE);
	assign adr_fifo_wdata[REC_ID_LSB   +: REC_FIELD_BITS] = REC_FIELD_BITS'(awid);
	assign adr_fifo_wdata[REC_LEN_LSB  +: REC_FIELD_BITS] = REC_FIELD_BITS'(awlen);
	// Sideband bytes
	assign adr_fifo_wdata[REC_SB_LSB   +: REC_FIELD_BITS] = '0;
	assign adr_fifo_wdata[REC_ADR_LSB  +: ADR_BITS]       = addr_aligned;

endmodule

`default_nettype wire

/* rtl/wr_data_pack.sv */
// --------------------------------------------------------------------------
// Write beat packing.
// Eight 64-bit beats fill one 512-bit word; a last beat flushes a partial
// word with its unused slots and strobes at zero.
// wready is combinational and depends on burst_open, resp_free and the
// data FIFO full level.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_data_pack (
	input  logic                                S_CLK,
	input  logic                                S_RESET_N,
	input  logic [wr_in_pkg::DATA_BITS-1:0]     wdata,
	input  logic [wr_in_pkg::STRB_BITS-1:0]     wstrb,
	input  logic                                wlast,
	input  logic                                wvalid,
	output logic                                wready,
	input  logic                                dat_fifo_full,
	output logic                                dat_fifo_wren,
	output logic [wr_in_pkg::DAT_REC_BITS-1:0]  dat_fifo_wdata,
	input  logic                                burst_open,
	input  logic                                resp_free,
	output logic                                last_taken
);
	import wr_in_pkg::*;

	logic [CNT_BITS-1:0]       cnt;
	logic                      word_end;
	logic                      beat;
	logic [WORD_BITS-1:0]      data_hold;
	logic [WORD_STRB_BITS-1:0] strb_hold;
	logic [WORD_BITS-1:0]      data_next;
	logic [WORD_STRB_BITS-1:0] strb_next;

	// ----------------------------------------------------------------------
	// Handshake
	// ----------------------------------------------------------------------
	assign word_end = (cnt == CNT_BITS'(BEATS_PER_WORD - 1));

	// Plain beats need only an open burst; flushing beats need FIFO room,
	// and a last beat also needs the response slot free
	always_comb begin
		wready = burst_open;
		if (word_end || wlast) begin
			wready = wready & ~dat_fifo_full;
		end
		if (wlast) begin
			wready = wready & resp_free;
		end
	end

	assign beat       = wvalid & wready;
	assign last_taken = beat & wlast;

	// Beat position within the current word
	always_ff @(posedge S_CLK or negedge S_RESET_N) begin
		if (!S_RESET_N) begin
			cnt <= '0;
		end else if (beat) begin
			if (wlast || word_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Lane packing
	// ----------------------------------------------------------------------
	// First beat of a word starts from zeros, later beats add to the held lanes
	always_comb begin
		if (cnt == '0) begin
			data_next = '0;
			strb_next = '0;
		end else begin
			data_next = data_hold;
			strb_next = strb_hold;
		end
		data_next[cnt * DATA_BITS +: DATA_BITS] = wdata;
		strb_next[cnt * STRB_BITS +: STRB_BITS] = wstrb;
	end

	always_ff @(posedge S_CLK) begin
		if (beat) begin
			data_hold <= data_next;
			strb_hold <= strb_next;
		end
	end

	assign dat_fifo_wren  = beat & (wlast | word_end);
	assign dat_fifo_wdata = {1'b0, wlast, strb_next, data_next};

endmodule

`default_nettype wire

/* rtl/wr_resp_stage.sv */
// --------------------------------------------------------------------------
// Write response.
// One response is held at a time; bvalid rises the cycle after the last
// beat and stays until bready. bresp is always OKAY.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_resp_stage (
	input  logic                          S_CLK,
	input  logic                          S_RESET_N,
	output logic [wr_in_pkg::ID_BITS-1:0] bid,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic                          last_taken,
	output logic                          burst_open,
	output logic                          resp_free,
	wr_id_if.pop_side                     q
);
	import wr_in_pkg::*;

	// Oldest queued ID belongs to the burst whose last beat is taken
	assign q.pop = last_taken;

	always_ff @(posedge S_CLK or negedge S_RESET_N) begin
		if (!S_RESET_N) begin
			bvalid <= 1'b0;
			bid    <= '0;
		end else if (bvalid && bready) begin
			bvalid <= 1'b0;
			bid    <= '0;
		end else if (last_taken) begin
			bvalid <= 1'b1;
			bid    <= q.pop_id;
		end
	end

	assign bresp = RESP_OKAY;

	// Status back to the data side
	assign burst_open = ~q.empty;
	assign resp_free  = ~bvalid;

endmodule

`default_nettype wire

/* rtl/wr_in_top.sv */
// --------------------------------------------------------------------------
// Write-side front end top level.
// Up to ID_DEPTH bursts may be accepted ahead of their data.
// Downstream FIFOs take a write enable with data and report a full level.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_in_top (
	input  logic                                S_CLK,
	input  logic                                S_RESET_N,
	// Write address channel
	input  logic [wr_in_pkg::ID_BITS-1:0]       awid,
	input  logic [wr_in_pkg::ADR_BITS-1:0]      awaddr,
	input  logic [wr_in_pkg::LEN_BITS-1:0]      awlen,
	input  logic                                awvalid,
	output logic                                awready,
	// Write data channel
	input  logic [wr_in_pkg::DATA_BITS-1:0]     wdata,
	input  logic [wr_in_pkg::STRB_BITS-1:0]     wstrb,
	input  logic                                wlast,
	input  logic                                wvalid,
	output logic                                wready,
	// Write response channel
	output logic [wr_in_pkg::ID_BITS-1:0]       bid,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  logic                                bready,
	// Downstream address FIFO
	input  logic                                adr_fifo_full,
	output logic                                adr_fifo_wren,
	output logic [wr_in_pkg::ADR_REC_BITS-1:0]  adr_fifo_wdata,
	// Downstream data FIFO
	input  logic                                dat_fifo_full,
	output logic                                dat_fifo_wren,
	output logic [wr_in_pkg::DAT_REC_BITS-1:0]  dat_fifo_wdata
);

	logic last_taken;
	logic burst_open;
	logic resp_free;

	wr_id_if id_q ();

	wr_id_fifo u_id_fifo (
		.S_CLK     (S_CLK),
		.S_RESET_N (S_RESET_N),
		.q         (id_q)
	);

	wr_addr_stage u_addr (
		.S_CLK          (S_CLK),
		.S_RESET_N      (S_RESET_N),
		.awid           (awid),
		.awaddr         (awaddr),
		.awlen          (awlen),
		.awvalid        (awvalid),
		.awready        (awready),
		.adr_fifo_full  (adr_fifo_full),
		.adr_fifo_wren  (adr_fifo_wren),
		.adr_fifo_wdata (adr_fifo_wdata),
		.q              (id_q)
	);

	wr_data_pack u_data (
		.S_CLK          (S_CLK),
		.S_RESET_N      (S_RESET_N),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wlast          (wlast),
		.wvalid         (wvalid),
		.wready         (wready),
		.dat_fifo_full  (dat_fifo_full),
		.dat_fifo_wren  (dat_fifo_wren),
		.dat_fifo_wdata (dat_fifo_wdata),
		.burst_open     (burst_open),
		.resp_free      (resp_free),
		.last_taken     (last_taken)
	);

	wr_resp_stage u_resp (
		.S_CLK      (S_CLK),
		.S_RESET_N  (S_RESET_N),
		.bid        (bid),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.last_taken (last_taken),
		.burst_open (burst_open),
		.resp_free  (resp_free),
		.q          (id_q)
	);

endmodule

`default_nettype wire

/* test/wr_in_chk.sv */
// --------------------------------------------------------------------------
// Protocol assertions bound into the write-side front end top level.
// errors counts failed assertions and is read by the testbench.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_in_chk (
	input  logic                          S_CLK,
	input  logic                          S_RESET_N,
	input  logic                          awready,
	input  logic                          bvalid,
	input  logic                          bready,
	input  logic [wr_in_pkg::ID_BITS-1:0] bid,
	input  logic                          adr_fifo_full,
	input  logic                          adr_fifo_wren,
	input  logic                          dat_fifo_full,
	input  logic                          dat_fifo_wren
);

	int errors = 0;

	// ----------------------------------------------------------------------
	// Address and response channels
	// ----------------------------------------------------------------------
	awready_pulse: assert property (@(posedge S_CLK) disable iff (!S_RESET_N)
		awready |=> !awready)
		else begin
			errors++;
			$error("awready stayed high for two cycles");
		end

	bvalid_hold: assert property (@(posedge S_CLK) disable iff (!S_RESET_N)
		bvalid && !bready |=> bvalid)
		else begin
			errors++;
			$error("bvalid dropped before bready");
		end

	bid_steady: assert property (@(posedge S_CLK) disable iff (!S_RESET_N)
		bvalid && !bready |=> $stable(bid))
		else begin
			errors++;
			$error("bid changed while bvalid waited");
		end

	// Downstream FIFOs
	adr_no_overflow: assert property (@(posedge S_CLK) disable iff (!S_RESET_N)
		!(adr_fifo_wren && adr_fifo_full))
		else begin
			errors++;
			$error("address FIFO written while full");
		end

	dat_no_overflow: assert property (@(posedge S_CLK) disable iff (!S_RESET_N)
		!(dat_fifo_wren && dat_fifo_full))
		else begin
			errors++;
			$error("data FIFO written while full");
		end

endmodule

`default_nettype wire

/* test/wr_in_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the write-side front end.
// Downstream FIFOs are modelled by random full levels; bready is random.
// Expected records are queued by the stimulus and checked at negedge.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wr_in_tb;
	import wr_in_pkg::*;

	localparam int N_BURSTS = 13;

	logic S_CLK;
	logic S_RESET_N;
	logic awvalid, awready, wlast, wvalid, wready, bvalid;
	logic adr_fifo_wren, dat_fifo_wren;
	logic bready = 1'b0;
	logic adr_fifo_full = 1'b0;
	logic dat_fifo_full = 1'b0;
	logic [ID_BITS-1:0]      awid, bid;
	logic [ADR_BITS-1:0]     awaddr;
	logic [LEN_BITS-1:0]     awlen;
	logic [DATA_BITS-1:0]    wdata;
	logic [STRB_BITS-1:0]    wstrb;
	logic [1:0]              bresp;
	logic [ADR_REC_BITS-1:0] adr_fifo_wdata;
	logic [DAT_REC_BITS-1:0] dat_fifo_wdata;
	logic [15:0]             lfsr = 16'd79;
	logic [ADR_REC_BITS-1:0] exp_adr [$];
	logic [DAT_REC_BITS-1:0] exp_dat [$];
	logic [ID_BITS-1:0]      exp_bid [$];
	logic                    prev_adr_full = 1'b0;
	int                      outstanding = 0;

	wr_in_top dut (.*);
	bind wr_in_top wr_in_chk chk (.*);

	always #10 S_CLK = ~S_CLK;

	// Taps 16, 14, 13, 11
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], next_bit()};
		return v;
	endfunction

	task automatic fail_text(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic fail_value(input string name, input logic [DAT_REC_BITS-1:0] exp,
			input logic [DAT_REC_BITS-1:0] act);
		fail_text($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic send_addr(input logic [ID_BITS-1:0] id, input logic [ADR_BITS-1:0] addr,
			input logic [LEN_BITS-1:0] len);
		exp_adr.push_back({16'd3, 16'(id), 16'(len), 16'h0, addr & ~64'h7});
		exp_bid.push_back(id);
		awid = id;
		awaddr = addr;
		awlen = len;
		awvalid = 1'b1;
		do @(negedge S_CLK); while (!awready);
		@(posedge S_CLK);
		#1 awvalid = 1'b0;
	endtask

	task automatic send_data(input int beats);
		logic [WORD_BITS-1:0]      word;
		logic [WORD_STRB_BITS-1:0] strb;
		int                        slot;
		word = '0;
		strb = '0;
		slot = 0;
		for (int i = 0; i < beats; i++) begin
			wdata = rand_bits(64);
			wstrb = STRB_BITS'(rand_bits(8));
			wlast = (i == beats - 1);
			wvalid = 1'b1;
			word[slot*64 +: 64] = wdata;
			strb[slot*8 +: 8] = wstrb;
			if (slot == 7 || wlast) begin
				exp_dat.push_back({1'b0, wlast, strb, word});
				word = '0;
				strb = '0;
				slot = 0;
			end else begin
				slot++;
			end
			do @(negedge S_CLK); while (!wready);
			@(posedge S_CLK);
			#1;
		end
		wvalid = 1'b0;
	endtask

	// Negative len0 picks random lengths of up to 16 beats
	task automatic run_bursts(input int n, input int hold, input int len0);
		int lens [$];
		for (int i = 0; i < n; i++)
			lens.push_back(len0 >= 0 ? len0 : int'(rand_bits(4)));
		fork
			for (int i = 0; i < n; i++)
				send_addr(ID_BITS'(rand_bits(8)), rand_bits(64), LEN_BITS'(lens[i]));
			begin
				repeat (hold) @(posedge S_CLK);
				#1;
				for (int i = 0; i < n; i++)
					send_data(lens[i] + 1);
			end
		join
	endtask

	// Downstream back-pressure, full only raised while no awready is pending
	always @(posedge S_CLK) begin
		#1;
		bready = next_bit() | next_bit();
		dat_fifo_full = next_bit() & next_bit();
		if (!awready)
			adr_fifo_full = next_bit() & next_bit();
	end

	// ----------------------------------------------------------------------
	// Output checks
	// ----------------------------------------------------------------------
	always @(negedge S_CLK) begin
		assert (dut.chk.errors == 0) else fail_text("A bound protocol assertion failed");
		if (!S_RESET_N) begin
			assert (!awready && !wready && !bvalid && !adr_fifo_wren && !dat_fifo_wren)
				else fail_text("Outputs active during reset");
		end else begin
			assert (!(awready && prev_adr_full))
				else fail_text("awready raised after a full address FIFO cycle");
			if (awvalid && awready) begin
				assert (outstanding < ID_DEPTH) else fail_text("Address accepted beyond ID depth");
				outstanding++;
			end
			if (wvalid && wready && wlast)
				outstanding--;
			if (adr_fifo_wren) begin
				assert (exp_adr.size() > 0) else fail_text("Unexpected address FIFO write");
				assert (adr_fifo_wdata == exp_adr[0]) else fail_value("address_record",
					DAT_REC_BITS'(exp_adr[0]), DAT_REC_BITS'(adr_fifo_wdata));
				void'(exp_adr.pop_front());
			end
			if (dat_fifo_wren) begin
				assert (exp_dat.size() > 0) else fail_text("Unexpected data FIFO write");
				assert (dat_fifo_wdata == exp_dat[0])
					else fail_value("data_record", exp_dat[0], dat_fifo_wdata);
				void'(exp_dat.pop_front());
			end
			if (bvalid && bready) begin
				assert (exp_bid.size() > 0) else fail_text("Unexpected write response");
				assert ({bresp, bid} == {2'b00, exp_bid[0]}) else fail_value("response",
					DAT_REC_BITS'({2'b00, exp_bid[0]}), DAT_REC_BITS'({bresp, bid}));
				void'(exp_bid.pop_front());
			end
		end
		prev_adr_full = adr_fifo_full;
	end

	initial begin
		#(N_BURSTS * 200 * 20);
		fail_text("Timeout with the DUT stalled");
	end

	initial begin
		S_CLK = 1'b0;
		S_RESET_N = 1'b0;
		awvalid = 1'b0;
		awid = '0;
		awaddr = '0;
		awlen = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		repeat (3) @(posedge S_CLK);
		#1 S_RESET_N = 1'b1;
		@(negedge S_CLK);
		assert (!awready && !wready && !bvalid) else fail_text("Outputs active after reset");
		@(posedge S_CLK);
		#1;
		run_bursts(1, 0, 15);
		run_bursts(1, 0, 2);
		// Nine addresses ahead of the data, the ninth must wait
		run_bursts(9, 60, -1);
		run_bursts(2, 0, -1);
		while (exp_bid.size() != 0)
			@(negedge S_CLK);
		if (exp_adr.size() != 0 || exp_dat.size() != 0) begin
			fail_text("Expected records were never written");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* files.f */
rtl/wr_in_pkg.sv
rtl/wr_id_if.sv
rtl/wr_id_fifo.sv
rtl/wr_addr_stage.sv
rtl/wr_data_pack.sv
rtl/wr_resp_stage.sv
rtl/wr_in_top.sv
test/wr_in_chk.sv
test/wr_in_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the write front end regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wr_in_tb -f files.f -o wr_in_sim
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

# Let the testbench see assertion failures and stop on its own
out=$(./obj_dir/wr_in_sim +verilator+error+limit+10 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
